// ==== Bender.yml ====
package:
  name: pipe_core

sources:
  - src/core_pkg.sv
  - src/fetch_stage.sv
  - src/decoder.sv
  - src/reg_file.sv
  - src/hazard_unit.sv
  - src/execute_stage.sv
  - src/pipe_regs.sv
  - src/pipe_core.sv
  - target: test
    files:
      - tb/pipe_core_tb.sv

// ==== pipe_core.f ====
src/core_pkg.sv
src/fetch_stage.sv
src/decoder.sv
src/reg_file.sv
src/hazard_unit.sv
src/execute_stage.sv
src/pipe_regs.sv
src/pipe_core.sv
tb/pipe_core_tb.sv

// ==== src/core_pkg.sv ====
package core_pkg;

	// widths fixed by RV64I
	typedef logic [63:0] xlen_t;
	typedef logic [63:0] addr_t;
	typedef logic [31:0] inst_t;
	typedef logic [4:0]  reg_idx_t;
	typedef logic [1:0]  alu_op_t;

	localparam alu_op_t ALU_ADD = 2'd0;
	localparam alu_op_t ALU_SUB = 2'd1;
	localparam alu_op_t ALU_AND = 2'd2;
	localparam alu_op_t ALU_OR  = 2'd3;

	// major opcodes
	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_LOAD   = 7'b0000011;
	localparam logic [6:0] OPC_STORE  = 7'b0100011;

	// addi x0, x0, 0
	localparam inst_t NOP_INST = 32'h0000_0013;
	localparam addr_t RESET_PC = 64'h0;

	localparam logic [1:0] FWD_NONE = 2'd0;
	localparam logic [1:0] FWD_MEM  = 2'd1;
	localparam logic [1:0] FWD_WB   = 2'd2;

	typedef struct packed {
		logic    reg_write;
		logic    mem_read;
		logic    mem_write;
		logic    alu_src;
		logic    mem_to_reg;
		alu_op_t alu_op;
	} ctrl_t;

	typedef struct packed {
		inst_t inst;
		addr_t pc;
	} if_id_t;

	typedef struct packed {
		ctrl_t    ctrl;
		xlen_t    rs1_val;
		xlen_t    rs2_val;
		xlen_t    imm;
		reg_idx_t rs1;
		reg_idx_t rs2;
		reg_idx_t rd;
	} id_ex_t;

	typedef struct packed {
		logic     reg_write;
		logic     mem_read;
		logic     mem_write;
		logic     mem_to_reg;
		xlen_t    alu_out;
		xlen_t    store_data;
		reg_idx_t rd;
	} ex_mem_t;

	typedef struct packed {
		logic     reg_write;
		logic     mem_to_reg;
		xlen_t    alu_out;
		xlen_t    mem_data;
		reg_idx_t rd;
	} mem_wb_t;

endpackage

// ==== src/decoder.sv ====
`timescale 1ns/1ps

module decoder import core_pkg::*; (
	input  inst_t    inst,
	output ctrl_t    ctrl,
	output reg_idx_t rs1,
	output reg_idx_t rs2,
	output reg_idx_t rd,
	output xlen_t    imm
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic       uses_rs1;
	logic       uses_rs2;

	assign opcode = inst[6:0];
	assign funct3 = inst[14:12];

	always_comb begin
		ctrl     = '0;
		uses_rs1 = 1'b0;
		uses_rs2 = 1'b0;
		imm      = '0;
		case (opcode)
			OPC_OP: begin
				ctrl.reg_write = 1'b1;
				uses_rs1       = 1'b1;
				uses_rs2       = 1'b1;
				case (funct3)
					3'b111:  ctrl.alu_op = ALU_AND;
					3'b110:  ctrl.alu_op = ALU_OR;
					default: ctrl.alu_op = inst[30] ? ALU_SUB : ALU_ADD;
				endcase
			end
			OPC_OP_IMM: begin
				ctrl.reg_write = 1'b1;
				ctrl.alu_src   = 1'b1;
				ctrl.alu_op    = ALU_ADD;
				uses_rs1       = 1'b1;
				imm            = {{52{inst[31]}}, inst[31:20]};
			end
			OPC_LOAD: begin
				ctrl.reg_write  = 1'b1;
				ctrl.mem_read   = 1'b1;
				ctrl.mem_to_reg = 1'b1;
				ctrl.alu_src    = 1'b1;
				ctrl.alu_op     = ALU_ADD;
				uses_rs1        = 1'b1;
				imm             = {{52{inst[31]}}, inst[31:20]};
			end
			OPC_STORE: begin
				ctrl.mem_write = 1'b1;
				ctrl.alu_src   = 1'b1;
				ctrl.alu_op    = ALU_ADD;
				uses_rs1       = 1'b1;
				uses_rs2       = 1'b1;
				// S-type splits the offset around rd's slot
				imm            = {{52{inst[31]}}, inst[31:25], inst[11:7]};
			end
			default: ;
		endcase
	end

	// unused source fields read as x0 so they never cause a stall
	assign rs1 = uses_rs1 ? inst[19:15] : '0;
	assign rs2 = uses_rs2 ? inst[24:20] : '0;
	assign rd  = inst[11:7];

endmodule

// ==== src/execute_stage.sv ====
`timescale 1ns/1ps

module execute_stage import core_pkg::*; (
	input  id_ex_t      id_ex,
	input  logic [1:0]  fwd_a,
	input  logic [1:0]  fwd_b,
	input  xlen_t       mem_fwd,
	input  xlen_t       wb_fwd,
	output xlen_t       alu_out,
	output xlen_t       store_data
);

	xlen_t op_a;
	xlen_t op_b_reg;
	xlen_t op_b;

	always_comb begin
		case (fwd_a)
			FWD_MEM: op_a = mem_fwd;
			FWD_WB:  op_a = wb_fwd;
			default: op_a = id_ex.rs1_val;
		endcase
	end

	// forwarded rs2 also feeds the store data path
	always_comb begin
		case (fwd_b)
			FWD_MEM: op_b_reg = mem_fwd;
			FWD_WB:  op_b_reg = wb_fwd;
			default: op_b_reg = id_ex.rs2_val;
		endcase
	end

	assign op_b       = id_ex.ctrl.alu_src ? id_ex.imm : op_b_reg;
	assign store_data = op_b_reg;

	always_comb begin
		case (id_ex.ctrl.alu_op)
			ALU_SUB: alu_out = op_a - op_b;
			ALU_AND: alu_out = op_a & op_b;
			ALU_OR:  alu_out = op_a | op_b;
			default: alu_out = op_a + op_b;
		endcase
	end

endmodule

// ==== src/fetch_stage.sv ====
`timescale 1ns/1ps

module fetch_stage import core_pkg::*; (
	input  logic   clk,
	input  logic   arst_n,
	input  logic   stall,
	input  inst_t  imem_rdata,
	output addr_t  imem_addr,
	output if_id_t if_id
);

	addr_t pc;

	// pc drives the fetch address and the word comes back in the same cycle
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pc <= RESET_PC;
		end else if (!stall) begin
			pc <= pc + 64'd4;
		end
	end

	// IF/ID starts out as a nop so decode sees no spurious work
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			if_id.inst <= NOP_INST;
			if_id.pc   <= RESET_PC;
		end else if (!stall) begin
			if_id.inst <= imem_rdata;
			if_id.pc   <= pc;
		end
	end

	assign imem_addr = pc;

endmodule

// ==== src/hazard_unit.sv ====
`timescale 1ns/1ps

module hazard_unit import core_pkg::*; (
	input  reg_idx_t    dec_rs1,
	input  reg_idx_t    dec_rs2,
	input  id_ex_t      id_ex,
	input  ex_mem_t     ex_mem,
	input  mem_wb_t     mem_wb,
	output logic        stall,
	output logic [1:0]  fwd_a,
	output logic [1:0]  fwd_b
);

	logic mem_hit_a;
	logic mem_hit_b;
	logic wb_hit_a;
	logic wb_hit_b;

	// load in EX whose result the decoding instruction needs
	assign stall = id_ex.ctrl.mem_read && (id_ex.rd != '0) &&
		((id_ex.rd == dec_rs1) || (id_ex.rd == dec_rs2));

	assign mem_hit_a = ex_mem.reg_write && (ex_mem.rd != '0) && (ex_mem.rd == id_ex.rs1);
	assign mem_hit_b = ex_mem.reg_write && (ex_mem.rd != '0) && (ex_mem.rd == id_ex.rs2);
	assign wb_hit_a  = mem_wb.reg_write && (mem_wb.rd != '0) && (mem_wb.rd == id_ex.rs1);
	assign wb_hit_b  = mem_wb.reg_write && (mem_wb.rd != '0) && (mem_wb.rd == id_ex.rs2);

	// younger result in EX/MEM takes priority
	always_comb begin
		fwd_a = FWD_NONE;
		if (mem_hit_a) begin
			fwd_a = FWD_MEM;
		end else if (wb_hit_a) begin
			fwd_a = FWD_WB;
		end
	end

	always_comb begin
		fwd_b = FWD_NONE;
		if (mem_hit_b) begin
			fwd_b = FWD_MEM;
		end else if (wb_hit_b) begin
			fwd_b = FWD_WB;
		end
	end

endmodule

// ==== src/pipe_core.sv ====
`timescale 1ns/1ps

module pipe_core import core_pkg::*; (
	input  logic     clk,
	input  logic     arst_n,
	output addr_t    imem_addr,
	input  inst_t    imem_rdata,
	output addr_t    dmem_addr,
	output xlen_t    dmem_wdata,
	output logic     dmem_we,
	input  xlen_t    dmem_rdata,
	output logic     wb_valid,
	output reg_idx_t wb_rd,
	output xlen_t    wb_data
);

	if_id_t     if_id;
	id_ex_t     dec;
	id_ex_t     id_ex;
	ex_mem_t    ex_mem;
	mem_wb_t    mem_wb;
	logic       stall;
	logic [1:0] fwd_a;
	logic [1:0] fwd_b;
	xlen_t      alu_out;
	xlen_t      store_data;

	fetch_stage fetch_i (
		.clk, .arst_n, .stall, .imem_rdata, .imem_addr, .if_id
	);

	decoder decoder_i (
		.inst (if_id.inst),
		.ctrl (dec.ctrl),
		.rs1  (dec.rs1),
		.rs2  (dec.rs2),
		.rd   (dec.rd),
		.imm  (dec.imm)
	);

	// register file writes straight from MEM/WB
	reg_file rf_i (
		.clk, .arst_n,
		.rs1     (dec.rs1),
		.rs2     (dec.rs2),
		.rs1_val (dec.rs1_val),
		.rs2_val (dec.rs2_val),
		.we      (mem_wb.reg_write),
		.wr_idx  (mem_wb.rd),
		.wr_data (wb_data)
	);

	hazard_unit hazard_i (
		.dec_rs1 (dec.rs1), .dec_rs2 (dec.rs2),
		.id_ex, .ex_mem, .mem_wb, .stall, .fwd_a, .fwd_b
	);

	execute_stage execute_i (
		.id_ex, .fwd_a, .fwd_b,
		.mem_fwd (ex_mem.alu_out),
		.wb_fwd  (wb_data),
		.alu_out, .store_data
	);

	pipe_regs regs_i (
		.clk, .arst_n, .stall, .dec, .alu_out, .store_data, .dmem_rdata,
		.id_ex, .ex_mem, .mem_wb
	);

	assign dmem_addr  = ex_mem.alu_out;
	assign dmem_wdata = ex_mem.store_data;
	assign dmem_we    = ex_mem.mem_write;

	// commit port mirrors the register file write
	assign wb_data  = mem_wb.mem_to_reg ? mem_wb.mem_data : mem_wb.alu_out;
	assign wb_rd    = mem_wb.rd;
	assign wb_valid = mem_wb.reg_write && (mem_wb.rd != '0);

endmodule

// ==== src/pipe_regs.sv ====
`timescale 1ns/1ps

module pipe_regs import core_pkg::*; (
	input  logic    clk,
	input  logic    arst_n,
	input  logic    stall,
	input  id_ex_t  dec,
	input  xlen_t   alu_out,
	input  xlen_t   store_data,
	input  xlen_t   dmem_rdata,
	output id_ex_t  id_ex,
	output ex_mem_t ex_mem,
	output mem_wb_t mem_wb
);

	// a stall turns the ID/EX slot into a bubble
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			id_ex <= '0;
		end else begin
			id_ex <= dec;
			if (stall) begin
				id_ex.ctrl <= '0;
			end
		end
	end

	// EX/MEM
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ex_mem <= '0;
		end else begin
			ex_mem.reg_write  <= id_ex.ctrl.reg_write;
			ex_mem.mem_read   <= id_ex.ctrl.mem_read;
			ex_mem.mem_write  <= id_ex.ctrl.mem_write;
			ex_mem.mem_to_reg <= id_ex.ctrl.mem_to_reg;
			ex_mem.alu_out    <= alu_out;
			ex_mem.store_data <= store_data;
			ex_mem.rd         <= id_ex.rd;
		end
	end

	// MEM/WB latches read data only for loads
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			mem_wb <= '0;
		end else begin
			mem_wb.reg_write  <= ex_mem.reg_write;
			mem_wb.mem_to_reg <= ex_mem.mem_to_reg;
			mem_wb.alu_out    <= ex_mem.alu_out;
			mem_wb.mem_data   <= ex_mem.mem_read ? dmem_rdata : '0;
			mem_wb.rd         <= ex_mem.rd;
		end
	end

endmodule

// ==== src/reg_file.sv ====
`timescale 1ns/1ps

module reg_file import core_pkg::*; (
	input  logic     clk,
	input  logic     arst_n,
	input  reg_idx_t rs1,
	input  reg_idx_t rs2,
	output xlen_t    rs1_val,
	output xlen_t    rs2_val,
	input  logic     we,
	input  reg_idx_t wr_idx,
	input  xlen_t    wr_data
);

	xlen_t regs [32];
	logic  wr_ok;

	// x0 is never written, so it reads zero forever
	assign wr_ok = we && (wr_idx != '0);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_ok) begin
			regs[wr_idx] <= wr_data;
		end
	end

	// write-back in the same cycle wins over the stored value
	assign rs1_val = (wr_ok && wr_idx == rs1) ? wr_data : regs[rs1];
	assign rs2_val = (wr_ok && wr_idx == rs2) ? wr_data : regs[rs2];

endmodule

// ==== tb/pipe_core_tb.sv ====
`timescale 1ns/1ps

module pipe_core_tb import core_pkg::*; ();

	logic     clk;
	logic     arst_n;
	addr_t    imem_addr;
	inst_t    imem_rdata;
	addr_t    dmem_addr;
	xlen_t    dmem_wdata;
	logic     dmem_we;
	xlen_t    dmem_rdata;
	logic     wb_valid;
	reg_idx_t wb_rd;
	xlen_t    wb_data;

	inst_t    imem [64];
	xlen_t    dmem [128];
	xlen_t    ref_mem [128];
	inst_t    prog [$];
	reg_idx_t exp_rd [$];
	xlen_t    exp_val [$];
	int       exp_cyc [$];
	addr_t    st_addr [$];
	xlen_t    st_data [$];
	int       cyc;
	logic [63:0] rng_state = 64'd20756;

	pipe_core dut_i (
		.clk, .arst_n, .imem_addr, .imem_rdata, .dmem_addr, .dmem_wdata,
		.dmem_we, .dmem_rdata, .wb_valid, .wb_rd, .wb_data
	);

	always #50 clk = ~clk;

	// both memories answer in the same cycle
	assign imem_rdata = (imem_addr < 64'd256) ? imem[imem_addr[7:2]] : NOP_INST;
	assign dmem_rdata = dmem[dmem_addr[9:3]];

	always @(posedge clk) begin
		if (dmem_we) begin
			dmem[dmem_addr[9:3]] <= dmem_wdata;
		end
	end

	// cycle 0 is the first cycle after reset release
	always @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			cyc <= 0;
		end else begin
			cyc <= cyc + 1;
		end
	end

	function automatic logic [63:0] next_random();
		rng_state ^= rng_state << 13;
		rng_state ^= rng_state >> 7;
		rng_state ^= rng_state << 17;
		return rng_state;
	endfunction

	function automatic xlen_t fill_word(input addr_t a);
		return (a * 64'h9e37_79b9_7f4a_7c15) ^ {a[31:0], a[63:32]};
	endfunction

	function automatic inst_t r_word(input logic [6:0] f7, input logic [2:0] f3,
			input reg_idx_t rd, input reg_idx_t rs1, input reg_idx_t rs2);
		return {f7, rs2, rs1, f3, rd, OPC_OP};
	endfunction

	function automatic inst_t i_word(input logic [6:0] opc, input logic [2:0] f3,
			input reg_idx_t rd, input reg_idx_t rs1, input logic [11:0] imm);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic inst_t add_rr(input reg_idx_t rd, input reg_idx_t rs1, input reg_idx_t rs2);
		return r_word(7'h00, 3'b000, rd, rs1, rs2);
	endfunction

	function automatic inst_t sub_rr(input reg_idx_t rd, input reg_idx_t rs1, input reg_idx_t rs2);
		return r_word(7'h20, 3'b000, rd, rs1, rs2);
	endfunction

	function automatic inst_t and_rr(input reg_idx_t rd, input reg_idx_t rs1, input reg_idx_t rs2);
		return r_word(7'h00, 3'b111, rd, rs1, rs2);
	endfunction

	function automatic inst_t or_rr(input reg_idx_t rd, input reg_idx_t rs1, input reg_idx_t rs2);
		return r_word(7'h00, 3'b110, rd, rs1, rs2);
	endfunction

	function automatic inst_t addi_ri(input reg_idx_t rd, input reg_idx_t rs1,
			input logic [11:0] imm);
		return i_word(OPC_OP_IMM, 3'b000, rd, rs1, imm);
	endfunction

	function automatic inst_t ld_ri(input reg_idx_t rd, input reg_idx_t rs1,
			input logic [11:0] imm);
		return i_word(OPC_LOAD, 3'b011, rd, rs1, imm);
	endfunction

	function automatic inst_t sd_ri(input reg_idx_t rs2, input reg_idx_t rs1,
			input logic [11:0] imm);
		return {imm[11:5], rs2, rs1, 3'b011, imm[4:0], OPC_STORE};
	endfunction

	task automatic stop_with_failure();
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic check_xlen(input string name, input xlen_t got, input xlen_t exp);
		if (got !== exp) begin
			$display("mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
			stop_with_failure();
		end
	endtask

	task automatic check_addr(input string name, input addr_t got, input addr_t exp);
		if (got !== exp) begin
			$display("mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
			stop_with_failure();
		end
	endtask

	task automatic check_reg_idx(input string name, input reg_idx_t got, input reg_idx_t exp);
		if (got !== exp) begin
			$display("mismatch at %0t: %s is x%0d, expected x%0d", $time, name, got, exp);
			stop_with_failure();
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("mismatch at %0t: %s is %b, expected %b", $time, name, got, exp);
			stop_with_failure();
		end
	endtask

	task automatic check_cycle(input string name, input int got, input int exp);
		if (got != exp) begin
			$display("mismatch at %0t: %s is %0d, expected %0d", $time, name, got, exp);
			stop_with_failure();
		end
	endtask

	task automatic load_memories();
		for (int i = 0; i < 64; i++) begin
			imem[i] = (i < prog.size()) ? prog[i] : NOP_INST;
		end
		for (int i = 0; i < 128; i++) begin
			dmem[i] = fill_word(addr_t'(i * 8));
		end
	endtask

	task automatic reset_and_load();
		@(posedge clk);
		#1;
		arst_n = 1'b0;
		load_memories();
		repeat (16) @(posedge clk);
		#1;
		arst_n = 1'b1;
	endtask

	// in-order ISA model that counts load-use bubbles for commit timing
	task automatic build_reference();
		xlen_t    regs [32];
		inst_t    w;
		reg_idx_t rd;
		reg_idx_t rs1;
		reg_idx_t rs2;
		reg_idx_t load_rd;
		logic     was_load;
		logic     reads_rs2;
		xlen_t    a;
		xlen_t    b;
		xlen_t    res;
		addr_t    ea;
		int       stalls;
		exp_rd.delete();
		exp_val.delete();
		exp_cyc.delete();
		st_addr.delete();
		st_data.delete();
		for (int i = 0; i < 128; i++) begin
			ref_mem[i] = fill_word(addr_t'(i * 8));
		end
		for (int i = 0; i < 32; i++) begin
			regs[i] = '0;
		end
		stalls = 0;
		was_load = 1'b0;
		load_rd = '0;
		foreach (prog[k]) begin
			w = prog[k];
			rd = w[11:7];
			rs1 = w[19:15];
			rs2 = w[24:20];
			reads_rs2 = (w[6:0] == OPC_OP) || (w[6:0] == OPC_STORE);
			if (was_load && load_rd != 0 &&
					(rs1 == load_rd || (reads_rs2 && rs2 == load_rd))) begin
				stalls++;
			end
			a = regs[rs1];
			b = regs[rs2];
			res = '0;
			case (w[6:0])
				OPC_OP: begin
					case (w[14:12])
						3'b111:  res = a & b;
						3'b110:  res = a | b;
						default: res = w[30] ? a - b : a + b;
					endcase
				end
				OPC_OP_IMM: res = a + {{52{w[31]}}, w[31:20]};
				OPC_LOAD: begin
					ea = a + {{52{w[31]}}, w[31:20]};
					res = ref_mem[ea[9:3]];
				end
				OPC_STORE: begin
					ea = a + {{52{w[31]}}, w[31:25], w[11:7]};
					ref_mem[ea[9:3]] = b;
					st_addr.push_back(ea);
					st_data.push_back(b);
				end
				default: ;
			endcase
			if (w[6:0] != OPC_STORE && rd != 0) begin
				regs[rd] = res;
				exp_rd.push_back(rd);
				exp_val.push_back(res);
				exp_cyc.push_back(k + 4 + stalls);
			end
			was_load = (w[6:0] == OPC_LOAD);
			load_rd = rd;
		end
	endtask

	task automatic collect_results(input string name);
		int idx;
		int st;
		int waited;
		int limit;
		idx = 0;
		st = 0;
		waited = 0;
		limit = prog.size() + 30;
		while (idx < exp_rd.size() || st < st_addr.size()) begin
			if (waited >= limit) begin
				if (idx < exp_rd.size()) begin
					$display("timeout in %s: commit %0d to x%0d never arrived", name, idx,
						exp_rd[idx]);
				end else begin
					$display("timeout in %s: store %0d never reached dmem", name, st);
				end
				stop_with_failure();
			end
			@(negedge clk);
			waited++;
			if (dmem_we) begin
				if (st >= st_addr.size()) begin
					$display("unexpected store to %h in %s", dmem_addr, name);
					stop_with_failure();
				end else begin
					check_addr("dmem_addr", dmem_addr, st_addr[st]);
					check_xlen("dmem_wdata", dmem_wdata, st_data[st]);
					st++;
				end
			end
			if (wb_valid) begin
				if (idx >= exp_rd.size()) begin
					$display("unexpected commit to x%0d in %s", wb_rd, name);
					stop_with_failure();
				end else begin
					check_reg_idx("wb_rd", wb_rd, exp_rd[idx]);
					check_xlen("wb_data", wb_data, exp_val[idx]);
					check_cycle("commit cycle", cyc, exp_cyc[idx]);
					idx++;
				end
			end
		end
		// trailing nops must stay silent
		repeat (6) begin
			@(negedge clk);
			check_bit("wb_valid", wb_valid, 1'b0);
			check_bit("dmem_we", dmem_we, 1'b0);
		end
		for (int i = 0; i < 128; i++) begin
			check_xlen($sformatf("dmem[%0d]", i * 8), dmem[i], ref_mem[i]);
		end
	endtask

	task automatic run_program(input string name);
		build_reference();
		reset_and_load();
		collect_results(name);
	endtask

	task automatic add_nops(input int n);
		repeat (n) prog.push_back(NOP_INST);
	endtask

	task automatic test_reset_state();
		prog.delete();
		reset_and_load();
		@(negedge clk);
		check_addr("imem_addr", imem_addr, RESET_PC);
		check_bit("wb_valid", wb_valid, 1'b0);
		check_bit("dmem_we", dmem_we, 1'b0);
	endtask

	task automatic test_alu_independent();
		prog.delete();
		prog.push_back(addi_ri(1, 0, 12'd1234));
		prog.push_back(addi_ri(2, 0, 12'hf9c));
		add_nops(3);
		prog.push_back(add_rr(3, 1, 2));
		add_nops(3);
		prog.push_back(sub_rr(4, 1, 2));
		add_nops(3);
		prog.push_back(and_rr(5, 1, 2));
		add_nops(3);
		prog.push_back(or_rr(6, 1, 2));
		add_nops(3);
		prog.push_back(addi_ri(7, 1, 12'h800));
		run_program("independent alu");
	endtask

	task automatic test_forwarding();
		prog.delete();
		prog.push_back(addi_ri(1, 0, 12'd5));
		prog.push_back(addi_ri(2, 1, 12'd3));
		prog.push_back(add_rr(3, 2, 1));
		prog.push_back(sub_rr(4, 3, 1));
		add_nops(1);
		prog.push_back(or_rr(5, 4, 3));
		// x6 read three instructions after its write
		prog.push_back(addi_ri(6, 0, 12'd100));
		add_nops(2);
		prog.push_back(addi_ri(7, 6, 12'd1));
		prog.push_back(and_rr(8, 7, 7));
		run_program("forwarding");
	endtask

	task automatic test_store_load();
		prog.delete();
		prog.push_back(addi_ri(1, 0, 12'd64));
		prog.push_back(addi_ri(2, 0, 12'hb2e));
		prog.push_back(sd_ri(2, 1, 12'd8));
		prog.push_back(ld_ri(3, 1, 12'd8));
		prog.push_back(ld_ri(4, 1, 12'd16));
		prog.push_back(add_rr(5, 3, 1));
		run_program("store then load");
	endtask

	task automatic test_load_use();
		prog.delete();
		prog.push_back(addi_ri(1, 0, 12'd40));
		add_nops(3);
		prog.push_back(ld_ri(2, 1, 12'd0));
		prog.push_back(add_rr(3, 2, 2));
		prog.push_back(addi_ri(4, 3, 12'd1));
		prog.push_back(ld_ri(5, 1, 12'd8));
		prog.push_back(sd_ri(5, 1, 12'd24));
		prog.push_back(ld_ri(6, 1, 12'd24));
		prog.push_back(or_rr(7, 6, 4));
		run_program("load use");
	endtask

	task automatic test_random();
		logic [63:0] r;
		reg_idx_t    rd;
		prog.delete();
		for (int i = 0; i < 40; i++) begin
			r = next_random();
			// every eighth destination is x0
			rd = (i % 8 == 7) ? 5'd0 : r[12:8];
			case (r[2:0])
				3'd3:    prog.push_back(add_rr(rd, r[17:13], r[22:18]));
				3'd4:    prog.push_back(sub_rr(rd, r[17:13], r[22:18]));
				3'd5:    prog.push_back(and_rr(rd, r[17:13], r[22:18]));
				3'd6:    prog.push_back(or_rr(rd, r[17:13], r[22:18]));
				default: prog.push_back(addi_ri(rd, r[17:13], r[34:23]));
			endcase
		end
		run_program("random alu");
	endtask

	initial begin
		clk = 1'b0;
		arst_n = 1'b0;
		prog.delete();
		load_memories();
		test_reset_state();
		test_alu_independent();
		test_forwarding();
		test_store_load();
		test_load_use();
		test_random();
		$display("Simulation completed successfully");
		$finish;
	end

endmodule
